/* rtl/routerPkg.sv */
`default_nettype none

package routerPkg;

  localparam int unsigned NUM_PORTS = 5;

  typedef logic [31:0] flitData_t;
  typedef logic [2:0] flitId_t;
  typedef logic [11:0] pktLength_t;              // Also the hold limit of a timer
  typedef logic [NUM_PORTS-1:0] portMask_t;      // Bit 0 is Local, then N, E, W, S

  localparam flitId_t FLIT_HEADER = 3'd1;        // Only a header loads the length
  localparam flitId_t FLIT_BODY = 3'd2;
  localparam flitId_t FLIT_TAIL = 3'd3;

  // Port order is also the rotation order
  localparam int unsigned PORT_L = 0;
  localparam int unsigned PORT_N = 1;
  localparam int unsigned PORT_E = 2;
  localparam int unsigned PORT_W = 3;
  localparam int unsigned PORT_S = 4;

  // Bit 0 is idle, the upper bits line up with portMask_t
  typedef enum logic [NUM_PORTS:0]
  {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

endpackage

`default_nettype wire

/* rtl/holdTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module holdTimer
  import routerPkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire flitId_t    flitId,
  input  wire pktLength_t length,
  input  wire logic       run,
  output logic            timesUp
);

  pktLength_t limit;
  pktLength_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEADER)
      begin
        limit <= length;                         // Loaded even when not granted
      end
      if (run)
      begin
        count <= pktLength_t'(count + 1'b1);
      end
      else
      begin
        count <= '0;                             // Any cycle off hold starts over
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

/* rtl/outputArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import routerPkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       LReq,
  input  wire logic       NReq,
  input  wire logic       EReq,
  input  wire logic       WReq,
  input  wire logic       SReq,
  input  wire flitId_t    LFlitId,
  input  wire flitId_t    NFlitId,
  input  wire flitId_t    EFlitId,
  input  wire flitId_t    WFlitId,
  input  wire flitId_t    SFlitId,
  input  wire pktLength_t LLength,
  input  wire pktLength_t NLength,
  input  wire pktLength_t ELength,
  input  wire pktLength_t WLength,
  input  wire pktLength_t SLength,
  output portMask_t       grant
);

  arbState_t state;
  arbState_t nextState;
  portMask_t reqVec;
  portMask_t timesUp;
  portMask_t run;
  logic hold;
  int unsigned start;

  // First requester at or after start, wrapping round the ports
  function automatic portMask_t rotatePick(portMask_t req, int unsigned first);
    portMask_t pick;
    int unsigned idx;
    pick = '0;
    for (int unsigned i = 0; i < NUM_PORTS; i++)
    begin
      idx = (first + i) % NUM_PORTS;
      if (req[idx] && (pick == '0))
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic arbState_t toState(portMask_t pick);
    arbState_t st;
    if (pick == '0)
    begin
      st = ST_IDLE;
    end
    else
    begin
      st = arbState_t'({pick, 1'b0});
    end
    return st;
  endfunction

  assign reqVec = {SReq, WReq, EReq, NReq, LReq};

  holdTimer lTimer
  (
    .clk(clk),
    .rst(rst),
    .flitId(LFlitId),
    .length(LLength),
    .run(run[PORT_L]),
    .timesUp(timesUp[PORT_L])
  );

  holdTimer nTimer
  (
    .clk(clk),
    .rst(rst),
    .flitId(NFlitId),
    .length(NLength),
    .run(run[PORT_N]),
    .timesUp(timesUp[PORT_N])
  );

  holdTimer eTimer
  (
    .clk(clk),
    .rst(rst),
    .flitId(EFlitId),
    .length(ELength),
    .run(run[PORT_E]),
    .timesUp(timesUp[PORT_E])
  );

  holdTimer wTimer
  (
    .clk(clk),
    .rst(rst),
    .flitId(WFlitId),
    .length(WLength),
    .run(run[PORT_W]),
    .timesUp(timesUp[PORT_W])
  );

  holdTimer sTimer
  (
    .clk(clk),
    .rst(rst),
    .flitId(SFlitId),
    .length(SLength),
    .run(run[PORT_S]),
    .timesUp(timesUp[PORT_S])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    run = '0;
    hold = |(grant & reqVec & ~timesUp);         // Owner still asking and under its limit
    case (state)
      ST_IDLE: start = PORT_L;
      ST_L:    start = PORT_N;
      ST_N:    start = PORT_E;
      ST_E:    start = PORT_W;
      ST_W:    start = PORT_S;
      default: start = PORT_L;                   // South wraps to Local
    endcase
    if (hold)
    begin
      nextState = state;
      run = grant;
    end
    else
    begin
      // The owner comes last in the search, so it may win again
      nextState = toState(rotatePick(reqVec, start));
    end
  end

  assign grant = portMask_t'(state[NUM_PORTS:1]);

endmodule

`default_nettype wire

/* rtl/flitSwitch.sv */
`timescale 1ns/1ps
`default_nettype none

module flitSwitch
  import routerPkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire portMask_t grant,
  input  wire logic      LReq,
  input  wire logic      NReq,
  input  wire logic      EReq,
  input  wire logic      WReq,
  input  wire logic      SReq,
  input  wire flitData_t LFlit,
  input  wire flitData_t NFlit,
  input  wire flitData_t EFlit,
  input  wire flitData_t WFlit,
  input  wire flitData_t SFlit,
  input  wire flitId_t   LFlitId,
  input  wire flitId_t   NFlitId,
  input  wire flitId_t   EFlitId,
  input  wire flitId_t   WFlitId,
  input  wire flitId_t   SFlitId,
  output flitData_t      outFlit,
  output flitId_t        outFlitId,
  output logic           outValid
);

  flitData_t flits [NUM_PORTS];
  flitId_t ids [NUM_PORTS];
  portMask_t reqVec;
  flitData_t selFlit;
  flitId_t selId;
  logic selValid;

  assign flits[PORT_L] = LFlit;
  assign flits[PORT_N] = NFlit;
  assign flits[PORT_E] = EFlit;
  assign flits[PORT_W] = WFlit;
  assign flits[PORT_S] = SFlit;
  assign ids[PORT_L] = LFlitId;
  assign ids[PORT_N] = NFlitId;
  assign ids[PORT_E] = EFlitId;
  assign ids[PORT_W] = WFlitId;
  assign ids[PORT_S] = SFlitId;
  assign reqVec = {SReq, WReq, EReq, NReq, LReq};

  // AND-OR mux, grant is one-hot
  always_comb
  begin
    selFlit = '0;
    selId = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        selFlit = selFlit | flits[p];
        selId = selId | ids[p];
      end
    end
    selValid = |(grant & reqVec);                // Owner must still be presenting a flit
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outFlitId <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
      if (selValid)
      begin
        outFlit <= selFlit;                      // Holds its last value while not valid
        outFlitId <= selId;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/outputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module outputPort
  import routerPkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire flitData_t  LFlit,
  input  wire flitId_t    LFlitId,
  input  wire pktLength_t LLength,
  input  wire logic       LReq,
  input  wire flitData_t  NFlit,
  input  wire flitId_t    NFlitId,
  input  wire pktLength_t NLength,
  input  wire logic       NReq,
  input  wire flitData_t  EFlit,
  input  wire flitId_t    EFlitId,
  input  wire pktLength_t ELength,
  input  wire logic       EReq,
  input  wire flitData_t  WFlit,
  input  wire flitId_t    WFlitId,
  input  wire pktLength_t WLength,
  input  wire logic       WReq,
  input  wire flitData_t  SFlit,
  input  wire flitId_t    SFlitId,
  input  wire pktLength_t SLength,
  input  wire logic       SReq,
  output wire portMask_t  grant,
  output wire flitData_t  outFlit,
  output wire flitId_t    outFlitId,
  output wire logic       outValid
);

  outputArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .LReq(LReq),
    .NReq(NReq),
    .EReq(EReq),
    .WReq(WReq),
    .SReq(SReq),
    .LFlitId(LFlitId),
    .NFlitId(NFlitId),
    .EFlitId(EFlitId),
    .WFlitId(WFlitId),
    .SFlitId(SFlitId),
    .LLength(LLength),
    .NLength(NLength),
    .ELength(ELength),
    .WLength(WLength),
    .SLength(SLength),
    .grant(grant)
  );

  // Grant is registered, so a flit leaves two edges after its request
  flitSwitch switch
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .LReq(LReq),
    .NReq(NReq),
    .EReq(EReq),
    .WReq(WReq),
    .SReq(SReq),
    .LFlit(LFlit),
    .NFlit(NFlit),
    .EFlit(EFlit),
    .WFlit(WFlit),
    .SFlit(SFlit),
    .LFlitId(LFlitId),
    .NFlitId(NFlitId),
    .EFlitId(EFlitId),
    .WFlitId(WFlitId),
    .SFlitId(SFlitId),
    .outFlit(outFlit),
    .outFlitId(outFlitId),
    .outValid(outValid)
  );

endmodule

`default_nettype wire

/* test/outputPortChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module outputPortChecker
  import routerPkg::*;
(
  input  wire logic        clk,
  input  wire logic        active,
  input  wire logic [31:0] testNum,
  input  wire portMask_t   expGrant,
  input  wire logic        expValid,
  input  wire flitId_t     expFlitId,
  input  wire flitData_t   expFlit,
  input  wire portMask_t   grant,
  input  wire logic        outValid,
  input  wire flitId_t     outFlitId,
  input  wire flitData_t   outFlit,
  output int               passCount,
  output int               errorCount
);

  int curTest = 0;
  int testCycles = 0;
  int testErrors = 0;
  int cycleErrors = 0;

  initial
  begin
    passCount = 0;
    errorCount = 0;
  end

  task automatic compareField(string field, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("error at %0d ns: test %0d %s expected %h, got %h",
               $time, curTest, field, expected, actual);
      cycleErrors++;
    end
  endtask

  task automatic reportTest();
    if (testErrors == 0)
    begin
      $display("test %0d passed over %0d cycles", curTest, testCycles);
    end
    else
    begin
      $display("test %0d failed with %0d errors over %0d cycles", curTest, testErrors,
               testCycles);
    end
  endtask

  // Sampled mid-cycle, well clear of the drive 1 ns after the edge
  always @(negedge clk)
  begin
    if (testNum != curTest)
    begin
      if (curTest != 0)
      begin
        reportTest();
      end
      curTest = testNum;
      testCycles = 0;
      testErrors = 0;
    end
    if (active)
    begin
      cycleErrors = 0;
      compareField("grant", expGrant, grant);
      compareField("outValid", expValid, outValid);
      compareField("outFlitId", expFlitId, outFlitId);   // Holds its value while not valid
      compareField("outFlit", expFlit, outFlit);
      testCycles++;
      testErrors += cycleErrors;
      errorCount += cycleErrors;
      if (cycleErrors == 0)
      begin
        passCount++;
      end
    end
  end

endmodule

`default_nettype wire

/* test/outputPortTb.sv */
`timescale 1ns/1ps
`default_nettype none

module outputPortTb
  import routerPkg::*;
();

  localparam int VEC_WORDS = 21;
  localparam int MAX_VECTORS = 64;
  localparam int DRIVE_DELAY = 1;

  logic clk;
  logic rst;
  portMask_t req;
  flitId_t flitId [NUM_PORTS];
  pktLength_t length [NUM_PORTS];
  flitData_t flit [NUM_PORTS];
  portMask_t grant;
  flitData_t outFlit;
  flitId_t outFlitId;
  logic outValid;
  logic active;
  logic [31:0] testNum;
  portMask_t expGrant;
  logic expValid;
  flitId_t expFlitId;
  flitData_t expFlit;
  int passCount;
  int errorCount;
  int numVectors = 0;
  int cycleCount = 0;
  int cycleLimit = 1000;
  logic [31:0] vecMem [0:MAX_VECTORS*VEC_WORDS-1];

  outputPort uut
  (
    .clk(clk),
    .rst(rst),
    .LFlit(flit[PORT_L]),
    .LFlitId(flitId[PORT_L]),
    .LLength(length[PORT_L]),
    .LReq(req[PORT_L]),
    .NFlit(flit[PORT_N]),
    .NFlitId(flitId[PORT_N]),
    .NLength(length[PORT_N]),
    .NReq(req[PORT_N]),
    .EFlit(flit[PORT_E]),
    .EFlitId(flitId[PORT_E]),
    .ELength(length[PORT_E]),
    .EReq(req[PORT_E]),
    .WFlit(flit[PORT_W]),
    .WFlitId(flitId[PORT_W]),
    .WLength(length[PORT_W]),
    .WReq(req[PORT_W]),
    .SFlit(flit[PORT_S]),
    .SFlitId(flitId[PORT_S]),
    .SLength(length[PORT_S]),
    .SReq(req[PORT_S]),
    .grant(grant),
    .outFlit(outFlit),
    .outFlitId(outFlitId),
    .outValid(outValid)
  );

  outputPortChecker portChecker
  (
    .clk(clk),
    .active(active),
    .testNum(testNum),
    .expGrant(expGrant),
    .expValid(expValid),
    .expFlitId(expFlitId),
    .expFlit(expFlit),
    .grant(grant),
    .outValid(outValid),
    .outFlitId(outFlitId),
    .outFlit(outFlit),
    .passCount(passCount),
    .errorCount(errorCount)
  );

  task automatic clearInputs();
    req = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      flitId[p] = '0;
      length[p] = '0;
      flit[p] = '0;
    end
    active = 1'b0;
    testNum = '0;
    expGrant = '0;
    expValid = 1'b0;
    expFlitId = '0;
    expFlit = '0;
  endtask

  // Word order per vector follows the columns of the vectors file
  task automatic applyVector(int v);
    int base;
    base = v * VEC_WORDS;
    testNum = vecMem[base];
    req = vecMem[base + 1][NUM_PORTS-1:0];
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      flitId[p] = vecMem[base + 2 + p][2:0];
      length[p] = vecMem[base + 7 + p][11:0];
      flit[p] = vecMem[base + 12 + p];
    end
    expGrant = vecMem[base + 17][NUM_PORTS-1:0];
    expValid = vecMem[base + 18][0];
    expFlitId = vecMem[base + 19][2:0];
    expFlit = vecMem[base + 20];
    active = 1'b1;
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    clearInputs();
    rst = 1'b1;
    $readmemh("test/outputPortVectors.txt", vecMem);
    while (numVectors < MAX_VECTORS && !$isunknown(vecMem[numVectors * VEC_WORDS])
           && vecMem[numVectors * VEC_WORDS] != 0)
    begin
      numVectors++;
    end
    cycleLimit = numVectors + 20;
    if (numVectors == 0)
    begin
      $display("no test vectors were read from test/outputPortVectors.txt");
    end
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    for (int v = 0; v < numVectors; v++)
    begin
      if (v > 0)
      begin
        @(posedge clk);
        #(DRIVE_DELAY);
      end
      applyVector(v);
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    clearInputs();                               // Test number 0 makes the checker close the last test
    @(posedge clk);
    $display("%0d of %0d cycles matched, %0d errors", passCount, numVectors, errorCount);
    if (errorCount == 0 && numVectors > 0 && passCount == numVectors)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/outputPortVectors.txt */
// test req idL idN idE idW idS lenL lenN lenE lenW lenS flitL flitN flitE flitW flitS
// then expected grant valid flitId flit while the line is driven, all hex, req bit 0 is Local
1 00 0 0 0 0 0 0 0 0 0 0 0  0  0  0  0 00 0 0 0
1 00 0 0 0 0 0 0 0 0 0 0 0  0  0  0  0 00 0 0 0
2 05 1 0 1 0 0 1 0 0 0 0 a1 0  e1 0  0 00 0 0 0
2 05 1 0 1 0 0 1 0 0 0 0 a1 0  e1 0  0 01 0 0 0
2 05 3 0 1 0 0 1 0 0 0 0 a2 0  e1 0  0 01 1 1 a1
2 06 0 1 1 0 0 0 3 0 0 0 0  b1 e1 0  0 04 1 3 a2
3 06 0 1 1 0 0 0 3 2 0 0 0  b1 e2 0  0 02 1 1 e1
3 06 0 2 1 0 0 0 0 2 0 0 0  b2 e2 0  0 02 1 1 b1
3 06 0 2 1 0 0 0 0 2 0 0 0  b3 e2 0  0 02 1 2 b2
3 06 0 3 1 0 0 0 0 2 0 0 0  b4 e2 0  0 02 1 2 b3
3 04 0 0 1 0 0 0 0 2 0 0 0  0  e2 0  0 04 1 3 b4
4 19 1 0 0 1 1 5 0 0 5 5 a4 0  0  c1 d1 04 1 1 e2
4 19 1 0 0 1 1 5 0 0 5 5 a4 0  0  c1 d1 08 0 1 e2
4 11 1 0 0 0 1 5 0 0 0 5 a4 0  0  0  d1 08 1 1 c1
4 11 1 0 0 0 1 5 0 0 0 5 a4 0  0  0  d1 10 0 1 c1
4 01 1 0 0 0 0 5 0 0 0 0 a4 0  0  0  0 10 1 1 d1
4 01 1 0 0 0 0 5 0 0 0 0 a4 0  0  0  0 01 0 1 d1
5 00 0 0 0 0 0 0 0 0 0 0 0  0  0  0  0 01 1 1 a4
5 00 0 0 0 0 0 0 0 0 0 0 0  0  0  0  0 00 0 1 a4
6 0a 0 1 0 1 0 0 2 0 0 0 0  b5 0  c2 0 00 0 1 a4
6 0a 0 1 0 1 0 0 2 0 0 0 0  b5 0  c2 0 02 0 1 a4
6 0a 0 2 0 1 0 0 7 0 0 0 0  b6 0  c2 0 02 1 1 b5
6 0a 0 2 0 1 0 0 7 0 0 0 0  b7 0  c2 0 02 1 2 b6
6 0a 0 3 0 1 0 0 7 0 0 0 0  b8 0  c2 0 08 1 2 b7
6 02 0 3 0 0 0 0 7 0 0 0 0  b8 0  0  0 02 1 1 c2

/* outputPort.f */
rtl/routerPkg.sv
rtl/holdTimer.sv
rtl/outputArbiter.sv
rtl/flitSwitch.sv
rtl/outputPort.sv
test/outputPortChecker.sv
test/outputPortTb.sv
